// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/ex_stage_tb.sv ====
// Execute stage testbench with rule-based reference models and immediate assertions
`timescale 1ns/1ps

module ex_stage_tb;
  import ex_pkg::*;

  ////////////////////
  // Run constants
  ////////////////////

  localparam int CLK_PERIOD = 4;
  localparam int ALU_REPS   = 4;
  localparam int MUL_REPS   = 6;
  localparam int HIGH_REPS  = 4;
  // Polling limit for one high-half multiply
  localparam int HIGH_WAIT  = 8;
  localparam int BP_HOLD    = 3;
  // Cycle budget per test, summed for the watchdog
  localparam int TOTAL_CYC  = 4 + (16 * ALU_REPS + 2) + (2 * MUL_REPS + 4)
                              + 3 * HIGH_REPS * (HIGH_WAIT + 2) + 10 + (BP_HOLD + 8);
  localparam int TIMEOUT_NS = (TOTAL_CYC + 100) * CLK_PERIOD;

  // DUT ports, names match for the .* hookup
  logic      clk = 1'b0;
  logic      rst_n;
  alu_op_t   alu_operator_i;
  word_t     alu_operand_a_i;
  word_t     alu_operand_b_i;
  word_t     alu_operand_c_i;
  logic      alu_en_i;
  mul_op_t   mult_operator_i;
  word_t     mult_operand_a_i;
  word_t     mult_operand_b_i;
  word_t     mult_operand_c_i;
  logic      mult_en_i;
  logic      csr_access_i;
  word_t     csr_rdata_i;
  logic      lsu_en_i;
  word_t     lsu_rdata_i;
  logic      lsu_ready_ex_i;
  logic      lsu_err_i;
  reg_addr_t regfile_alu_waddr_i;
  logic      regfile_alu_we_i;
  reg_addr_t regfile_waddr_i;
  logic      regfile_we_i;
  logic      branch_in_ex_i;
  logic      wb_ready_i;
  reg_addr_t regfile_alu_waddr_fw_o;
  logic      regfile_alu_we_fw_o;
  word_t     regfile_alu_wdata_fw_o;
  reg_addr_t regfile_waddr_wb_o;
  logic      regfile_we_wb_o;
  word_t     regfile_wdata_wb_o;
  word_t     jump_target_o;
  logic      branch_decision_o;
  logic      mult_multicycle_o;
  logic      ex_ready_o;
  logic      ex_valid_o;

  integer seed = 32'h33f1_4e5a;
  int     checks = 0;
  int     errors = 0;
  int     tests = 0;
  int     checks_mark = 0;
  int     errors_mark = 0;

  ex_stage u_ex_stage (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Reference rules
  ////////////////////

  function automatic word_t rand_word();
    return word_t'($random(seed));
  endfunction

  // Branch compare outcome, signed or unsigned per code
  function automatic logic compare_ref(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return $signed(a) < $signed(b);
      ALU_GE:  return !($signed(a) < $signed(b));
      ALU_LTU: return a < b;
      default: return !(a < b);
    endcase
  endfunction

  function automatic word_t alu_ref(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return compare_ref(op, a, b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // Full 64-bit product of the extended operands, upper word kept
  function automatic word_t high_ref(mul_op_t op, word_t a, word_t b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] p;
    ax = (op == MUL_HU) ? {32'd0, a} : {{32{a[31]}}, a};
    bx = (op == MUL_H) ? {{32{b[31]}}, b} : {32'd0, b};
    p  = ax * bx;
    return p[63:32];
  endfunction

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d checks, %0d failed", name, checks - checks_mark,
             errors - errors_mark);
    tests++;
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // Nothing enabled, LSU and WB ready
  task automatic drive_idle();
    alu_en_i         <= 1'b0;
    mult_en_i        <= 1'b0;
    csr_access_i     <= 1'b0;
    lsu_en_i         <= 1'b0;
    lsu_err_i        <= 1'b0;
    regfile_we_i     <= 1'b0;
    regfile_alu_we_i <= 1'b0;
    branch_in_ex_i   <= 1'b0;
    lsu_ready_ex_i   <= 1'b1;
    wb_ready_i       <= 1'b1;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    finish_test("reset");
  endtask

  task automatic test_alu();
    int        i;
    alu_op_t   op;
    word_t     a;
    word_t     b;
    word_t     c;
    reg_addr_t fw_addr;
    logic      fw_we;
    for (i = 0; i < 16 * ALU_REPS; i++) begin
      op      = alu_op_t'(i % 16);
      a       = rand_word();
      b       = rand_word();
      c       = rand_word();
      fw_addr = reg_addr_t'(rand_word());
      fw_we   = (i % 2 == 1);
      // Equal operands now and then so EQ and GE see both outcomes
      if ((rand_word() & 32'd3) == 32'd0) b = a;
      @(posedge clk);
      alu_en_i            <= 1'b1;
      alu_operator_i      <= op;
      alu_operand_a_i     <= a;
      alu_operand_b_i     <= b;
      alu_operand_c_i     <= c;
      regfile_alu_waddr_i <= fw_addr;
      regfile_alu_we_i    <= fw_we;
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o", alu_ref(op, a, b), regfile_alu_wdata_fw_o);
      check_word("jump_target_o", c, jump_target_o);
      // Forwarding target passes straight through
      check_word("regfile_alu_waddr_fw_o", word_t'(fw_addr), word_t'(regfile_alu_waddr_fw_o));
      check_bit("regfile_alu_we_fw_o", fw_we, regfile_alu_we_fw_o);
      if (op >= ALU_EQ) begin
        check_bit("branch_decision_o", compare_ref(op, a, b), branch_decision_o);
      end
    end
    @(posedge clk);
    drive_idle();
    finish_test("alu");
  endtask

  task automatic test_mul_csr();
    int    i;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    for (i = 0; i < 2 * MUL_REPS; i++) begin
      a = rand_word();
      b = rand_word();
      c = rand_word();
      @(posedge clk);
      mult_en_i        <= 1'b1;
      mult_operator_i  <= (i % 2 == 0) ? MUL_MUL : MUL_MAC;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      mult_operand_c_i <= c;
      @(negedge clk);
      check_word("regfile_alu_wdata_fw_o", (i % 2 == 0) ? a * b : a * b + c,
                 regfile_alu_wdata_fw_o);
      check_bit("ex_ready_o", 1'b1, ex_ready_o);
    end
    // CSR read beats a live multiply
    d = rand_word();
    @(posedge clk);
    csr_access_i    <= 1'b1;
    csr_rdata_i     <= d;
    mult_operator_i <= MUL_MUL;
    @(negedge clk);
    check_word("regfile_alu_wdata_fw_o", d, regfile_alu_wdata_fw_o);
    @(posedge clk);
    drive_idle();
    finish_test("mul_csr");
  endtask

  task automatic test_mul_high();
    int      i;
    int      waited;
    mul_op_t op;
    word_t   a;
    word_t   b;
    for (i = 0; i < 3 * HIGH_REPS; i++) begin
      op = (i % 3 == 0) ? MUL_H : ((i % 3 == 1) ? MUL_HSU : MUL_HU);
      a  = (i < 3) ? 32'h8000_0000 : rand_word();
      b  = (i < 3) ? 32'hffff_ffff : rand_word();
      @(posedge clk);
      mult_en_i        <= 1'b1;
      mult_operator_i  <= op;
      mult_operand_a_i <= a;
      mult_operand_b_i <= b;
      // Count stalled cycles until the stage accepts
      waited = 0;
      @(negedge clk);
      while (!ex_ready_o && waited < HIGH_WAIT) begin
        waited++;
        @(negedge clk);
      end
      if (waited == HIGH_WAIT) begin
        $display("Timeout at %0t, ex_ready_o stayed low on a high-half multiply", $time);
        errors++;
      end else begin
        check_word("ex_ready_o low cycles", 32'd2, word_t'(waited));
        check_bit("mult_multicycle_o", 1'b1, mult_multicycle_o);
        check_word("regfile_alu_wdata_fw_o", high_ref(op, a, b), regfile_alu_wdata_fw_o);
      end
    end
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_bit("mult_multicycle_o", 1'b0, mult_multicycle_o);
    finish_test("mul_high");
  endtask

  task automatic test_writeback();
    reg_addr_t addr;
    word_t     data;
    addr = reg_addr_t'(rand_word());
    data = rand_word();
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= addr;
    lsu_rdata_i     <= data;
    @(negedge clk);
    check_bit("ex_valid_o", 1'b1, ex_valid_o);
    @(posedge clk);
    lsu_en_i     <= 1'b0;
    regfile_we_i <= 1'b0;
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b1, regfile_we_wb_o);
    check_word("regfile_waddr_wb_o", word_t'(addr), word_t'(regfile_waddr_wb_o));
    check_word("regfile_wdata_wb_o", data, regfile_wdata_wb_o);
    // Idle cycle with WB ready drains the entry
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    // Faulting load
    @(posedge clk);
    lsu_en_i     <= 1'b1;
    regfile_we_i <= 1'b1;
    lsu_err_i    <= 1'b1;
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    finish_test("writeback");
  endtask

  task automatic test_backpressure();
    int        i;
    reg_addr_t addr;
    addr = reg_addr_t'(rand_word());
    @(posedge clk);
    lsu_en_i        <= 1'b1;
    regfile_we_i    <= 1'b1;
    regfile_waddr_i <= addr;
    @(posedge clk);
    wb_ready_i      <= 1'b0;
    // New address must not reach WB while stalled
    regfile_waddr_i <= ~addr;
    for (i = 0; i < BP_HOLD; i++) begin
      @(negedge clk);
      check_bit("ex_valid_o", 1'b0, ex_valid_o);
      check_bit("ex_ready_o", 1'b0, ex_ready_o);
      check_bit("regfile_we_wb_o", 1'b1, regfile_we_wb_o);
      check_word("regfile_waddr_wb_o", word_t'(addr), word_t'(regfile_waddr_wb_o));
    end
    // Branch in EX completes despite the stall
    @(posedge clk);
    branch_in_ex_i <= 1'b1;
    @(negedge clk);
    check_bit("ex_ready_o", 1'b1, ex_ready_o);
    check_bit("ex_valid_o", 1'b0, ex_valid_o);
    check_bit("regfile_we_wb_o", 1'b1, regfile_we_wb_o);
    @(posedge clk);
    drive_idle();
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b1, regfile_we_wb_o);
    @(negedge clk);
    check_bit("regfile_we_wb_o", 1'b0, regfile_we_wb_o);
    finish_test("backpressure");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    rst_n               <= 1'b0;
    alu_operator_i      <= ALU_ADD;
    alu_operand_a_i     <= '0;
    alu_operand_b_i     <= '0;
    alu_operand_c_i     <= '0;
    mult_operator_i     <= MUL_MUL;
    mult_operand_a_i    <= '0;
    mult_operand_b_i    <= '0;
    mult_operand_c_i    <= '0;
    csr_rdata_i         <= '0;
    lsu_rdata_i         <= '0;
    regfile_alu_waddr_i <= '0;
    regfile_waddr_i     <= '0;
    drive_idle();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_alu();
    test_mul_csr();
    test_mul_high();
    test_writeback();
    test_backpressure();
    $display("Summary: %0d tests, %0d checks, %0d failed", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the per-test cycle budget
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== ex_stage.f ====
rtl/ex_pkg.sv
rtl/ex_alu_if.sv
rtl/ex_mul_if.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_wb_reg.sv
rtl/ex_stage.sv
bench/ex_stage_tb.sv

// ==== rtl/ex_alu.sv ====
// Combinational integer ALU with add, logic, shift, set-less-than and branch compare
`timescale 1ns/1ps

module ex_alu (
  ex_alu_if.alu alu
);
  import ex_pkg::*;

  logic       is_sub;
  word_t      sum;
  logic [4:0] shamt;
  word_t      shift_l;
  word_t      shift_r;
  word_t      shift_ra;
  logic       lt_s;
  logic       lt_u;
  logic       eq;
  logic       cmp;
  word_t      res;

  ////////////////////
  // Datapath
  ////////////////////

  // One adder for add and sub, two's complement of B on sub
  assign is_sub = (alu.operator == ALU_SUB);
  assign sum    = alu.operand_a + (is_sub ? ~alu.operand_b : alu.operand_b)
                  + {{(XLEN-1){1'b0}}, is_sub};

  // Only the low five bits count for RV32 shifts
  assign shamt    = alu.operand_b[4:0];
  assign shift_l  = alu.operand_a << shamt;
  assign shift_r  = alu.operand_a >> shamt;
  assign shift_ra = word_t'($signed(alu.operand_a) >>> shamt);

  // Comparator flags shared by slt and branches
  assign lt_s = ($signed(alu.operand_a) < $signed(alu.operand_b));
  assign lt_u = (alu.operand_a < alu.operand_b);
  assign eq   = (alu.operand_a == alu.operand_b);

  ////////////////////
  // Branch compare
  ////////////////////

  always_comb begin
    case (alu.operator)
      ALU_EQ:  cmp = eq;
      ALU_NE:  cmp = ~eq;
      ALU_LT:  cmp = lt_s;
      ALU_GE:  cmp = ~lt_s;
      ALU_LTU: cmp = lt_u;
      ALU_GEU: cmp = ~lt_u;
      // No branch taken on non-compare codes
      default: cmp = 1'b0;
    endcase
  end

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    case (alu.operator)
      ALU_ADD,
      ALU_SUB:  res = sum;
      ALU_AND:  res = alu.operand_a & alu.operand_b;
      ALU_OR:   res = alu.operand_a | alu.operand_b;
      ALU_XOR:  res = alu.operand_a ^ alu.operand_b;
      ALU_SLL:  res = shift_l;
      ALU_SRL:  res = shift_r;
      ALU_SRA:  res = shift_ra;
      ALU_SLT:  res = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res = {{(XLEN-1){1'b0}}, lt_u};
      // Compare codes also return their 0/1 outcome
      default:  res = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

  // Idle ALU presents zero on the result bus
  assign alu.result     = alu.en ? res : '0;
  assign alu.cmp_result = cmp;

endmodule

// ==== rtl/ex_alu_if.sv ====
// ALU request and result bundle between the execute stage and the ALU
`timescale 1ns/1ps

interface ex_alu_if;
  import ex_pkg::*;

  // Request side, driven by the stage
  logic    en;
  alu_op_t operator;
  word_t   operand_a;
  word_t   operand_b;

  // Result side, purely combinational
  word_t   result;
  logic    cmp_result;

  modport alu (
    input  en, operator, operand_a, operand_b,
    output result, cmp_result
  );

  modport stage (
    output en, operator, operand_a, operand_b,
    input  result, cmp_result
  );

endinterface

// ==== rtl/ex_mul_if.sv ====
// Multiplier request, result and ready bundle between the execute stage and the multiplier
`timescale 1ns/1ps

interface ex_mul_if;
  import ex_pkg::*;

  // Request, held stable by ID while en is high and ready is low
  logic    en;
  mul_op_t operator;
  word_t   operand_a;
  word_t   operand_b;
  // Accumulator input for MAC
  word_t   operand_c;

  // Response
  word_t   result;
  logic    ready;
  // High in the final cycle of a high-half multiply
  logic    multicycle;

  modport mult (
    input  en, operator, operand_a, operand_b, operand_c,
    output result, ready, multicycle
  );

  modport stage (
    output en, operator, operand_a, operand_b, operand_c,
    input  result, ready, multicycle
  );

endinterface

// ==== rtl/ex_mult.sv ====
// Integer multiplier, single-cycle MUL/MAC and three-cycle MULH/MULHSU/MULHU
`timescale 1ns/1ps

module ex_mult (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ex_ready_i,
  ex_mul_if.mult mul
);
  import ex_pkg::*;

  mult_state_e                 state_q;
  mult_state_e                 state_d;
  logic                        is_high;
  logic                        start;
  logic                        a_sign;
  logic                        b_sign;
  logic signed [XLEN:0]        a_ext;
  logic signed [MUL_SLICE_W:0] b_lo;
  logic signed [MUL_SLICE_W:0] b_hi;
  logic signed [2*XLEN-1:0]    pp_lo;
  logic signed [2*XLEN-1:0]    pp_hi;
  logic [2*XLEN-1:0]           prod_q;
  word_t                       mul_lo;
  word_t                       mac_lo;

  ////////////////////
  // Operand prep
  ////////////////////

  assign is_high = (mul.operator == MUL_H) || (mul.operator == MUL_HSU)
                   || (mul.operator == MUL_HU);
  assign start   = (state_q == MULT_IDLE) && mul.en && is_high;

  // A signed for MULH and MULHSU, B signed for MULH only
  assign a_sign = ((mul.operator == MUL_H) || (mul.operator == MUL_HSU))
                  & mul.operand_a[XLEN-1];
  assign b_sign = (mul.operator == MUL_H) & mul.operand_b[XLEN-1];

  assign a_ext = {a_sign, mul.operand_a};
  // Low slice is always unsigned, high slice carries the sign
  assign b_lo  = {1'b0, mul.operand_b[MUL_SLICE_W-1:0]};
  assign b_hi  = {b_sign, mul.operand_b[XLEN-1:MUL_SLICE_W]};

  // Partial products, modulo 2^64 is enough for the upper word
  assign pp_lo = a_ext * b_lo;
  assign pp_hi = a_ext * b_hi;

  // Single-cycle path
  assign mul_lo = mul.operand_a * mul.operand_b;
  assign mac_lo = mul_lo + mul.operand_c;

  ////////////////////
  // High-half FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MULT_IDLE: if (start) state_d = MULT_STEP;
      MULT_STEP: state_d = MULT_DONE;
      // Wait for the stage to take the result
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // First cycle loads the low slice, second adds the shifted high slice
  always_ff @(posedge clk) begin
    if (start) begin
      prod_q <= pp_lo;
    end else if (state_q == MULT_STEP) begin
      prod_q <= prod_q + (pp_hi <<< MUL_SLICE_W);
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign mul.ready      = (state_q == MULT_DONE) || ((state_q == MULT_IDLE) && !start);
  assign mul.multicycle = (state_q == MULT_DONE);

  always_comb begin
    if (state_q == MULT_DONE) begin
      mul.result = prod_q[2*XLEN-1:XLEN];
    end else if (mul.operator == MUL_MAC) begin
      mul.result = mac_lo;
    end else begin
      mul.result = mul_lo;
    end
  end

  // A started high-half multiply answers by the third cycle
  a_high_done: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> ##[1:2] mul.ready);

  // Final cycle only shows while ID still holds the high-half request
  a_multicycle_held: assert property (@(posedge clk) disable iff (!rst_n)
    mul.multicycle |-> mul.en && is_high);

endmodule

// ==== rtl/ex_pkg.sv ====
// Execute stage package with word widths, operator codes and shared types
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Data word of the core
  localparam int XLEN        = 32;
  // Register address, MSB selects the FP bank
  localparam int REG_ADDR_W  = 6;
  localparam int ALU_OP_W    = 4;
  localparam int MUL_OP_W    = 3;
  // Operand B is consumed in two slices of this width by the high-half multiply
  localparam int MUL_SLICE_W = 16;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ALU_OP_W-1:0]   alu_op_t;
  typedef logic [MUL_OP_W-1:0]   mul_op_t;

  ////////////////////
  // ALU operators
  ////////////////////

  // Arithmetic and logic
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  // Shifts, amount taken from operand B
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  // Set less than
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  // Branch comparisons
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  ////////////////////
  // Multiplier
  ////////////////////

  // Single cycle low word
  localparam mul_op_t MUL_MUL = 3'd0;
  localparam mul_op_t MUL_MAC = 3'd1;
  // Three cycle high word
  localparam mul_op_t MUL_H   = 3'd4;
  localparam mul_op_t MUL_HSU = 3'd5;
  localparam mul_op_t MUL_HU  = 3'd6;

  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_STEP,
    MULT_DONE
  } mult_state_e;

endpackage

// ==== rtl/ex_stage.sv ====
// Execute stage top with ALU, multiplier, write-port muxes and stage handshake
`timescale 1ns/1ps

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,

  // ALU request from ID
  input  ex_pkg::alu_op_t   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  logic              alu_en_i,

  // Multiplier request from ID
  input  ex_pkg::mul_op_t   mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  input  logic              mult_en_i,

  // CSR and LSU
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,

  // Register file targets and branch flag
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              regfile_we_i,
  input  logic              branch_in_ex_i,

  input  logic              wb_ready_i,

  // Forwarding port to ID and register file
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,

  // Load writeback port
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,

  // Branch resolution to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,

  output logic              mult_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_alu_if alu_bus ();
  ex_mul_if mul_bus ();

  ////////////////////
  // ALU
  ////////////////////

  assign alu_bus.en        = alu_en_i;
  assign alu_bus.operator  = alu_operator_i;
  assign alu_bus.operand_a = alu_operand_a_i;
  assign alu_bus.operand_b = alu_operand_b_i;

  ex_alu u_ex_alu (
    .alu (alu_bus)
  );

  ////////////////////
  // Multiplier
  ////////////////////

  assign mul_bus.en        = mult_en_i;
  assign mul_bus.operator  = mult_operator_i;
  assign mul_bus.operand_a = mult_operand_a_i;
  assign mul_bus.operand_b = mult_operand_b_i;
  assign mul_bus.operand_c = mult_operand_c_i;

  ex_mult u_ex_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_ready_i (ex_ready_o),
    .mul        (mul_bus)
  );

  assign mult_multicycle_o = mul_bus.multicycle;

  ////////////////////
  // Write ports
  ////////////////////

  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;

  // CSR read wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mul_bus.result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_bus.result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  ex_wb_reg u_ex_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .lsu_err_i       (lsu_err_i),
    .regfile_we_i    (regfile_we_i),
    .regfile_waddr_i (regfile_waddr_i),
    .we_o            (regfile_we_wb_o),
    .waddr_o         (regfile_waddr_wb_o)
  );

  // Load data arrives straight from the LSU in WB
  assign regfile_wdata_wb_o = lsu_rdata_i;

  // Branch target comes in on operand C
  assign jump_target_o     = alu_operand_c_i;
  assign branch_decision_o = alu_bus.cmp_result;

  ////////////////////
  // Handshake
  ////////////////////

  // A branch finishes in EX without needing WB
  assign ex_ready_o = (mul_bus.ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mul_bus.ready & lsu_ready_ex_i & wb_ready_i;

endmodule

// ==== rtl/ex_wb_reg.sv ====
// EX/WB pipeline register holding the load writeback enable and address
`timescale 1ns/1ps

module ex_wb_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  input  logic              lsu_err_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output logic              we_o,
  output ex_pkg::reg_addr_t waddr_o
);

  logic load_we;

  // A faulting load never writes the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_o <= 1'b0;
    end else if (ex_valid_i) begin
      we_o <= load_we;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, drop the entry
      we_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      waddr_o <= regfile_waddr_i;
    end
  end

  a_no_err_write: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(we_o) |-> !$past(lsu_err_i));

endmodule
